// ==== src.f ====
hw/mem_map_pkg.sv
hw/boot_rom.sv
hw/ram_bank.sv
hw/axil_mem_bridge.sv
hw/mem_subsys_top.sv
bench/tb_mem_subsys.sv

// ==== Makefile ====
TOP := tb_mem_subsys

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

lint:
	verilator --lint-only hw/mem_map_pkg.sv hw/boot_rom.sv hw/ram_bank.sv \
	  hw/axil_mem_bridge.sv hw/mem_subsys_top.sv --top-module mem_subsys_top

clean:
	rm -rf obj_dir

// ==== bench/tb_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys
  import mem_map_pkg::*;
();

  localparam int          RAM_WORDS = 1024;
  localparam int          TIMEOUT   = 50;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic  clk, rst_n;
  addr_t awaddr, araddr;
  data_t wdata, rdata;
  strb_t wstrb;
  resp_t bresp, rresp;
  logic  awvalid, awready, wvalid, wready, bvalid, bready;
  logic  arvalid, arready, rvalid, rready;

  logic [31:0] lfsr_q;
  int          errors, checks;
  data_t       rom_model [ROM_WORDS];
  data_t       ram_model [int unsigned];
  strb_t       ram_known [int unsigned];

  mem_subsys_top #(.RamWords(RAM_WORDS)) uut (
    .clk_i(clk), .rst_ni(rst_n),
    .s_awaddr_i(awaddr), .s_awvalid_i(awvalid), .s_awready_o(awready),
    .s_wdata_i(wdata), .s_wstrb_i(wstrb), .s_wvalid_i(wvalid), .s_wready_o(wready),
    .s_bresp_o(bresp), .s_bvalid_o(bvalid), .s_bready_i(bready),
    .s_araddr_i(araddr), .s_arvalid_i(arvalid), .s_arready_o(arready),
    .s_rdata_o(rdata), .s_rresp_o(rresp), .s_rvalid_o(rvalid), .s_rready_i(rready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------
  // Helpers
  // --------------------
  // Galois LFSR, one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        b;
    v = '0;
    for (int i = 0; i < n; i++) begin
      b = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (b) lfsr_q = lfsr_q ^ LFSR_TAPS;
      v[i] = b;
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  function automatic data_t byte_mask(input strb_t s);
    data_t m;
    for (int b = 0; b < 8; b++) m[8*b +: 8] = {8{s[b]}};
    return m;
  endfunction

  // Both ends of the RAM, so words get written more than once
  function automatic int pick_ram_idx();
    int low;
    low = int'(rand_bits(5));
    if (rand_bits(1) != 0) return RAM_WORDS - 1 - low;
    return low;
  endfunction

  task automatic model_write(input int idx, input data_t wd, input strb_t ws);
    if (!ram_known.exists(idx)) begin
      ram_model[idx] = '0;
      ram_known[idx] = '0;
    end
    ram_model[idx] = (ram_model[idx] & ~byte_mask(ws)) | (wd & byte_mask(ws));
    ram_known[idx] = ram_known[idx] | ws;
  endtask

  // Bytes never written hold no known value
  task automatic check_ram(input int idx, input data_t rd);
    if (ram_known.exists(idx)) begin
      check_value("ram read data", ram_model[idx] & byte_mask(ram_known[idx]),
                  rd & byte_mask(ram_known[idx]));
    end
  endtask

  // --------------------
  // Bus transactions
  // --------------------
  // Called and left right after the drive point of a cycle
  task automatic write_txn(input addr_t addr, input data_t wd, input strb_t ws,
                           output resp_t resp);
    int cyc;
    int delay;
    awaddr  = addr;
    wdata   = wd;
    wstrb   = ws;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    cyc = 0;
    @(negedge clk);
    while (!(awready && wready) && cyc < TIMEOUT) begin
      @(negedge clk);
      cyc++;
    end
    if (!(awready && wready)) begin
      $display("Timeout waiting for the write address at %h to be taken", addr);
      errors++;
    end
    // A read offered at the same time has to wait
    check_value("arready during write", 0, arready);
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    cyc = 1;
    @(negedge clk);
    while (!bvalid && cyc < TIMEOUT) begin
      @(negedge clk);
      cyc++;
    end
    if (!bvalid) begin
      $display("Timeout waiting for the write response at %h", addr);
      errors++;
    end
    check_value("write latency", 1, cyc);
    resp  = bresp;
    delay = int'(rand_bits(2));
    repeat (delay) begin
      @(negedge clk);
      check_value("bvalid held", 1, bvalid);
      check_value("bresp stable", resp, bresp);
    end
    @(posedge clk);
    #1;
    bready = 1'b1;
    @(posedge clk);
    #1;
    bready = 1'b0;
    check_value("bvalid after accept", 0, bvalid);
  endtask

  task automatic read_txn(input addr_t addr, output data_t rd, output resp_t resp);
    int cyc;
    int delay;
    araddr  = addr;
    arvalid = 1'b1;
    cyc = 0;
    @(negedge clk);
    while (!arready && cyc < TIMEOUT) begin
      @(negedge clk);
      cyc++;
    end
    if (!arready) begin
      $display("Timeout waiting for the read address at %h to be taken", addr);
      errors++;
    end
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    cyc = 1;
    @(negedge clk);
    while (!rvalid && cyc < TIMEOUT) begin
      @(negedge clk);
      cyc++;
    end
    if (!rvalid) begin
      $display("Timeout waiting for the read data at %h", addr);
      errors++;
    end
    check_value("read latency", 2, cyc);
    rd    = rdata;
    resp  = rresp;
    delay = int'(rand_bits(2));
    repeat (delay) begin
      @(negedge clk);
      check_value("rvalid held", 1, rvalid);
      check_value("rdata stable", rd, rdata);
      check_value("rresp stable", resp, rresp);
    end
    @(posedge clk);
    #1;
    rready = 1'b1;
    @(posedge clk);
    #1;
    rready = 1'b0;
    check_value("rvalid after accept", 0, rvalid);
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    data_t rd;
    data_t wd;
    resp_t rs;
    addr_t addr;
    int    idx;
    int    idx_r;
    lfsr_q  = 32'd68666;
    errors  = 0;
    checks  = 0;
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    for (int i = 0; i < ROM_WORDS; i++) rom_model[i] = BOOT_IMAGE[i];

    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("bvalid after reset", 0, bvalid);
    check_value("rvalid after reset", 0, rvalid);
    @(posedge clk);
    #1;

    // ROM reads with random byte offsets
    for (int n = 0; n < 40; n++) begin
      idx  = int'(rand_bits(4));
      addr = ROM_BASE + addr_t'(idx * 8) + addr_t'(rand_bits(3));
      read_txn(addr, rd, rs);
      check_value("rom read resp", RESP_OKAY, rs);
      check_value("rom read data", rom_model[idx], rd);
    end

    // Mixed RAM writes and reads
    for (int n = 0; n < 80; n++) begin
      idx  = pick_ram_idx();
      addr = RAM_BASE + addr_t'(idx * 8) + addr_t'(rand_bits(3));
      if (rand_bits(1) != 0) begin
        wd = rand_bits(64);
        wstrb = strb_t'(rand_bits(8));
        write_txn(addr, wd, wstrb, rs);
        check_value("ram write resp", RESP_OKAY, rs);
        model_write(idx, wd, wstrb);
      end else begin
        read_txn(addr, rd, rs);
        check_value("ram read resp", RESP_OKAY, rs);
        check_ram(idx, rd);
      end
    end

    // ROM writes are refused and leave the image as it was
    for (int n = 0; n < 8; n++) begin
      idx  = int'(rand_bits(4));
      addr = ROM_BASE + addr_t'(idx * 8);
      write_txn(addr, rand_bits(64), 8'hff, rs);
      check_value("rom write resp", RESP_SLVERR, rs);
      read_txn(addr, rd, rs);
      check_value("rom readback", rom_model[idx], rd);
    end

    // Unmapped addresses, first the edges of both regions
    for (int n = 0; n < 24; n++) begin
      if (n == 0) addr = ROM_BASE + ROM_WORDS * 8;
      else if (n == 1) addr = ROM_BASE - 8;
      else if (n == 2) addr = RAM_BASE + RAM_WORDS * 8;
      else addr = addr_t'(rand_bits(32));
      if ((addr >= ROM_BASE && addr < ROM_BASE + ROM_WORDS * 8) ||
          (addr >= RAM_BASE && addr < RAM_BASE + RAM_WORDS * 8)) begin
        addr = addr ^ 32'h4000_0000;
      end
      write_txn(addr, rand_bits(64), 8'hff, rs);
      check_value("unmapped write resp", RESP_DECERR, rs);
      read_txn(addr, rd, rs);
      check_value("unmapped read resp", RESP_DECERR, rs);
      check_value("unmapped read data", 0, rd);
    end

    // Read and write offered together
    for (int n = 0; n < 20; n++) begin
      idx_r   = pick_ram_idx();
      idx     = pick_ram_idx();
      araddr  = RAM_BASE + addr_t'(idx_r * 8);
      arvalid = 1'b1;
      wd      = rand_bits(64);
      wstrb   = strb_t'(rand_bits(8));
      write_txn(RAM_BASE + addr_t'(idx * 8), wd, wstrb, rs);
      check_value("paired write resp", RESP_OKAY, rs);
      model_write(idx, wd, wstrb);
      read_txn(RAM_BASE + addr_t'(idx_r * 8), rd, rs);
      check_value("paired read resp", RESP_OKAY, rs);
      check_ram(idx_r, rd);
    end

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/mem_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// Memory subsystem: AXI4-Lite bridge, boot ROM and data RAM
module mem_subsys_top
  import mem_map_pkg::*;
#(
  parameter int unsigned RamWords = 1024
) (
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  input  wire addr_t s_awaddr_i,
  input  wire logic  s_awvalid_i,
  output logic       s_awready_o,
  input  wire data_t s_wdata_i,
  input  wire strb_t s_wstrb_i,
  input  wire logic  s_wvalid_i,
  output logic       s_wready_o,
  output resp_t      s_bresp_o,
  output logic       s_bvalid_o,
  input  wire logic  s_bready_i,
  input  wire addr_t s_araddr_i,
  input  wire logic  s_arvalid_i,
  output logic       s_arready_o,
  output data_t      s_rdata_o,
  output resp_t      s_rresp_o,
  output logic       s_rvalid_o,
  input  wire logic  s_rready_i
);

  // -------------------
  // Memory side wires
  // -------------------
  logic                        rom_req;
  rom_idx_t                    rom_idx;
  data_t                       rom_rdata;
  logic                        ram_req;
  logic                        ram_we;
  logic [$clog2(RamWords)-1:0] ram_idx;
  data_t                       ram_wdata;
  strb_t                       ram_strb;
  data_t                       ram_rdata;

  axil_mem_bridge #(
    .RamWords ( RamWords )
  ) i_bridge (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .s_awaddr_i  ( s_awaddr_i  ),
    .s_awvalid_i ( s_awvalid_i ),
    .s_awready_o ( s_awready_o ),
    .s_wdata_i   ( s_wdata_i   ),
    .s_wstrb_i   ( s_wstrb_i   ),
    .s_wvalid_i  ( s_wvalid_i  ),
    .s_wready_o  ( s_wready_o  ),
    .s_bresp_o   ( s_bresp_o   ),
    .s_bvalid_o  ( s_bvalid_o  ),
    .s_bready_i  ( s_bready_i  ),
    .s_araddr_i  ( s_araddr_i  ),
    .s_arvalid_i ( s_arvalid_i ),
    .s_arready_o ( s_arready_o ),
    .s_rdata_o   ( s_rdata_o   ),
    .s_rresp_o   ( s_rresp_o   ),
    .s_rvalid_o  ( s_rvalid_o  ),
    .s_rready_i  ( s_rready_i  ),
    .rom_req_o   ( rom_req     ),
    .rom_idx_o   ( rom_idx     ),
    .rom_rdata_i ( rom_rdata   ),
    .ram_req_o   ( ram_req     ),
    .ram_we_o    ( ram_we      ),
    .ram_idx_o   ( ram_idx     ),
    .ram_wdata_o ( ram_wdata   ),
    .ram_strb_o  ( ram_strb    ),
    .ram_rdata_i ( ram_rdata   )
  );

  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .idx_i   ( rom_idx   ),
    .rdata_o ( rom_rdata )
  );

  ram_bank #(
    .RamWords ( RamWords )
  ) i_ram_bank (
    .clk_i   ( clk_i     ),
    .req_i   ( ram_req   ),
    .we_i    ( ram_we    ),
    .idx_i   ( ram_idx   ),
    .wdata_i ( ram_wdata ),
    .strb_i  ( ram_strb  ),
    .rdata_o ( ram_rdata )
  );

endmodule

`default_nettype wire

// ==== hw/axil_mem_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

// AXI4-Lite slave in front of the boot ROM and the data RAM
module axil_mem_bridge
  import mem_map_pkg::*;
#(
  parameter int unsigned RamWords = 1024
) (
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,
  // Write address and data
  input  wire addr_t                       s_awaddr_i,
  input  wire logic                        s_awvalid_i,
  output logic                             s_awready_o,
  input  wire data_t                       s_wdata_i,
  input  wire strb_t                       s_wstrb_i,
  input  wire logic                        s_wvalid_i,
  output logic                             s_wready_o,
  // Write response
  output resp_t                            s_bresp_o,
  output logic                             s_bvalid_o,
  input  wire logic                        s_bready_i,
  // Read address
  input  wire addr_t                       s_araddr_i,
  input  wire logic                        s_arvalid_i,
  output logic                             s_arready_o,
  // Read data
  output data_t                            s_rdata_o,
  output resp_t                            s_rresp_o,
  output logic                             s_rvalid_o,
  input  wire logic                        s_rready_i,
  // Boot ROM
  output logic                             rom_req_o,
  output rom_idx_t                         rom_idx_o,
  input  wire data_t                       rom_rdata_i,
  // Data RAM
  output logic                             ram_req_o,
  output logic                             ram_we_o,
  output logic [$clog2(RamWords)-1:0]      ram_idx_o,
  output data_t                            ram_wdata_o,
  output strb_t                            ram_strb_o,
  input  wire data_t                       ram_rdata_i
);

  localparam int unsigned RamIdxW  = $clog2(RamWords);
  localparam addr_t       RomBytes = addr_t'(ROM_WORDS << WORD_OFFSET_BITS);
  localparam addr_t       RamBytes = addr_t'(RamWords << WORD_OFFSET_BITS);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ_WAIT,
    ST_READ_RESP,
    ST_WRITE_RESP
  } state_e;

  state_e state_q, state_d;

  logic  wr_offer, wr_hs, rd_hs;
  addr_t sel_addr, rom_off, ram_off;
  logic  hit_rom, hit_ram;
  resp_t sel_resp;

  resp_t resp_q;
  logic  rd_rom_q, rd_ram_q;
  data_t rdata_q;

  // -------------------
  // Handshakes
  // -------------------
  // Write takes priority, so a pending write blocks AR
  assign wr_offer    = s_awvalid_i && s_wvalid_i;
  assign s_awready_o = (state_q == ST_IDLE) && wr_offer;
  assign s_wready_o  = s_awready_o;
  assign s_arready_o = (state_q == ST_IDLE) && !wr_offer;

  assign wr_hs = s_awready_o;
  assign rd_hs = s_arready_o && s_arvalid_i;

  // -------------------
  // Address decode
  // -------------------
  // One decoder serves both channels
  assign sel_addr = wr_offer ? s_awaddr_i : s_araddr_i;
  assign rom_off  = sel_addr - ROM_BASE;
  assign ram_off  = sel_addr - RAM_BASE;
  assign hit_rom  = rom_off < RomBytes;
  assign hit_ram  = ram_off < RamBytes;

  always_comb begin
    if (hit_ram) begin
      sel_resp = RESP_OKAY;
    end else if (hit_rom) begin
      // ROM is read-only
      sel_resp = wr_offer ? RESP_SLVERR : RESP_OKAY;
    end else begin
      sel_resp = RESP_DECERR;
    end
  end

  // Memory requests go out on the handshake edge
  assign rom_req_o   = rd_hs && hit_rom;
  assign rom_idx_o   = rom_off[WORD_OFFSET_BITS +: $bits(rom_idx_t)];
  assign ram_req_o   = (wr_hs || rd_hs) && hit_ram;
  assign ram_we_o    = wr_hs;
  assign ram_idx_o   = ram_off[WORD_OFFSET_BITS +: RamIdxW];
  assign ram_wdata_o = s_wdata_i;
  assign ram_strb_o  = s_wstrb_i;

  // -------------------
  // FSM
  // -------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (wr_hs) begin
          state_d = ST_WRITE_RESP;
        end else if (rd_hs) begin
          state_d = ST_READ_WAIT;
        end
      end
      ST_READ_WAIT:  state_d = ST_READ_RESP;
      ST_READ_RESP:  state_d = s_rready_i ? ST_IDLE : ST_READ_RESP;
      ST_WRITE_RESP: state_d = s_bready_i ? ST_IDLE : ST_WRITE_RESP;
      default:       state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= ST_IDLE;
      resp_q   <= RESP_OKAY;
      rd_rom_q <= 1'b0;
      rd_ram_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (wr_hs || rd_hs) begin
        resp_q <= sel_resp;
      end
      if (rd_hs) begin
        rd_rom_q <= hit_rom;
        rd_ram_q <= hit_ram;
      end
    end
  end

  // Memory data is valid one cycle after the request
  always_ff @(posedge clk_i) begin
    if (state_q == ST_READ_WAIT) begin
      if (rd_rom_q) begin
        rdata_q <= rom_rdata_i;
      end else if (rd_ram_q) begin
        rdata_q <= ram_rdata_i;
      end else begin
        rdata_q <= '0;
      end
    end
  end

  // Only one transaction in flight, so B and R share the response
  assign s_bvalid_o = (state_q == ST_WRITE_RESP);
  assign s_bresp_o  = resp_q;
  assign s_rvalid_o = (state_q == ST_READ_RESP);
  assign s_rresp_o  = resp_q;
  assign s_rdata_o  = rdata_q;

  // -------------------
  // Assertions
  // -------------------
  a_r_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o)
  ) else $error("R payload dropped before rready");

  a_b_hold: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    s_bvalid_o && !s_bready_i |=> s_bvalid_o
  ) else $error("bvalid dropped before bready");

  a_one_mem: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(rom_req_o && ram_req_o)
  ) else $error("ROM and RAM requested together");

endmodule

`default_nettype wire

// ==== hw/ram_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

// Single-port data RAM with byte write strobes
module ram_bank
  import mem_map_pkg::*;
#(
  parameter int unsigned RamWords = 1024
) (
  input  wire logic                        clk_i,
  input  wire logic                        req_i,
  input  wire logic                        we_i,
  input  wire logic [$clog2(RamWords)-1:0] idx_i,
  input  wire data_t                       wdata_i,
  input  wire strb_t                       strb_i,
  output data_t                            rdata_o
);

  data_t mem_q [RamWords];

  // -------------------
  // Write and read port
  // -------------------
  // A write leaves the read register untouched
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < $bits(strb_t); b++) begin
          if (strb_i[b]) begin
            mem_q[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[idx_i];
      end
    end
  end

  // -------------------
  // Assertions
  // -------------------
  // Bridge decode must keep the index inside the array
  a_idx_in_range: assert property (
    @(posedge clk_i) req_i |-> (32'(idx_i) < RamWords)
  ) else $error("RAM index %0d out of range", idx_i);

endmodule

`default_nettype wire

// ==== hw/boot_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

// Read-only boot memory, one word per request
module boot_rom
  import mem_map_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     req_i,
  input  wire rom_idx_t idx_i,
  output data_t         rdata_o
);

  // -------------------
  // Read port
  // -------------------
  // Output register keeps the last word between requests
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= BOOT_IMAGE[idx_i];
    end
  end

endmodule

`default_nettype wire

// ==== hw/mem_map_pkg.sv ====
`default_nettype none

package mem_map_pkg;

  // -------------------
  // Bus widths
  // -------------------
  typedef logic [31:0] addr_t;
  typedef logic [63:0] data_t;
  typedef logic [7:0]  strb_t;
  typedef logic [1:0]  resp_t;

  // AXI response codes
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;
  localparam resp_t RESP_DECERR = 2'b11;

  // -------------------
  // Address map
  // -------------------
  // Byte offset inside a 64-bit word
  localparam int unsigned WORD_OFFSET_BITS = 3;

  localparam int unsigned ROM_WORDS = 16;
  localparam addr_t       ROM_BASE  = 32'h0001_0000;
  localparam addr_t       RAM_BASE  = 32'h8000_0000;

  typedef logic [$clog2(ROM_WORDS)-1:0] rom_idx_t;

  // -------------------
  // Boot image
  // -------------------
  // Two RV64 instructions per word, lower address in the low half
  localparam data_t BOOT_IMAGE [ROM_WORDS] = '{
    64'h0202_8593_0000_0297,  // auipc t0,0 / addi a1,t0,32
    64'h0182_b283_f140_2573,  // csrr a0,mhartid / ld t0,24(t0)
    64'h0000_0013_0002_8067,  // jr t0 / nop
    64'h0000_0000_8000_0000,  // Entry point in RAM
    64'h0000_0000_0001_0040,  // Pointer to device table
    64'h0000_0000_0000_0001,  // Number of harts
    64'hffdf_f06f_1050_0073,  // wfi / j -4
    64'h0000_0013_0000_0013,
    64'hd00d_feed_0000_0000,  // Device table header
    64'h0000_0000_0001_0000,  // ROM base
    64'h0000_0000_8000_0000,  // RAM base
    64'h0000_0000_0000_2000,  // RAM size
    64'h0000_0000_0000_0000,
    64'h0000_0000_0000_0000,
    64'h0000_0000_0000_0000,
    64'h5a5a_a5a5_0bad_c0de   // Image end marker
  };

endpackage

`default_nettype wire
